/* all.f */
logic/board_pkg.sv
logic/piece_pkg.sv
logic/input_conditioner.sv
logic/piece_rom.sv
logic/piece_controller.sv
logic/board_keeper.sv
logic/tetris_top.sv
verification/tetris_checker.sv
verification/tetris_tb.sv

/* logic/board_keeper.sv */
`timescale 1ns/1ps
`default_nettype none

module board_keeper (
    input  logic              clk,
    input  logic              reset,
    input  board_pkg::board_t mask_i,
    input  logic              merge_i,
    input  logic              clear_start_i,
    input  logic              show_piece_i,
    output board_pkg::board_t board_o,
    output logic              clear_done_o,
    output board_pkg::board_t display_o,
    output board_pkg::score_t score_o
);

    import board_pkg::*;

    board_t           board_q;
    score_t           score_q;
    logic             busy_q;
    logic [ROW_W-1:0] scan_row_q;
    logic             row_full;

    // Row under examination has every cell set
    assign row_full = &board_q[scan_row_q];

    // Scan finishes when the top row is checked and kept
    assign clear_done_o = busy_q && (scan_row_q == '0) && !row_full;

    //========================================
    // Board store and row clearing
    //========================================

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            board_q    <= '0;
            score_q    <= '0;
            busy_q     <= 1'b0;
            scan_row_q <= '0;
        end else if (merge_i) begin
            // Landed piece becomes part of the board
            board_q <= board_q | mask_i;
        end else if (clear_start_i && !busy_q) begin
            // Start from the bottom row
            busy_q     <= 1'b1;
            scan_row_q <= ROW_W'(BOARD_ROWS - 1);
        end else if (busy_q) begin
            if (row_full) begin
                // Drop everything above, fresh empty row on top
                for (int r = 1; r < BOARD_ROWS; r++) begin
                    if (r <= int'(scan_row_q))
                        board_q[r] <= board_q[r-1];
                end
                board_q[0] <= '0;
                score_q    <= score_q + SCORE_W'(1);
                // Same index is examined again next cycle
            end else if (scan_row_q == '0) begin
                busy_q <= 1'b0;
            end else begin
                scan_row_q <= scan_row_q - ROW_W'(1);
            end
        end
    end

    //========================================
    // Outputs
    //========================================

    assign board_o = board_q;
    assign score_o = score_q;

    // Falling piece overlaid only while it is live
    assign display_o = show_piece_i ? (board_q | mask_i) : board_q;

endmodule

`default_nettype wire

/* logic/board_pkg.sv */
`default_nettype none

// Playfield geometry and the types built on it
package board_pkg;

    //========================================
    // Dimensions
    //========================================

    // Twenty rows deep, ten columns wide
    localparam int BOARD_ROWS = 20;
    localparam int BOARD_COLS = 10;

    // Index widths for row and column counters
    localparam int ROW_W = 5;
    localparam int COL_W = 4;

    //========================================
    // Board types
    //========================================

    // One row, a set bit is an occupied cell
    typedef logic [BOARD_COLS-1:0] row_t;

    // Whole playfield, row 0 at the top
    typedef row_t [BOARD_ROWS-1:0] board_t;

    // Cleared-row counter, wraps at 256
    localparam int SCORE_W = 8;
    typedef logic [SCORE_W-1:0] score_t;

endpackage

`default_nettype wire

/* logic/input_conditioner.sv */
`timescale 1ns/1ps
`default_nettype none

module input_conditioner (
    input  logic clk,
    input  logic reset,
    input  logic drop_rate_i,
    input  logic left_i,
    input  logic right_i,
    input  logic rot_cw_i,
    input  logic rot_ccw_i,
    output logic drop_tick_o,
    output logic left_o,
    output logic right_o,
    output logic rot_cw_o,
    output logic rot_ccw_o
);

    // All five asynchronous inputs handled as one group
    typedef struct packed {
        logic drop;
        logic left;
        logic right;
        logic rot_cw;
        logic rot_ccw;
    } evt_t;

    evt_t raw;
    evt_t sync0_q, sync1_q, prev_q;
    evt_t rise, fall, edge_d, pulse_q;

    assign raw = '{drop_rate_i, left_i, right_i, rot_cw_i, rot_ccw_i};

    // Two-flop synchronizer, then one more stage for edge history
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sync0_q <= '0;
            sync1_q <= '0;
            prev_q  <= '0;
            pulse_q <= '0;
        end else begin
            sync0_q <= raw;
            sync1_q <= sync0_q;
            prev_q  <= sync1_q;
            pulse_q <= edge_d;
        end
    end

    // Buttons fire on press, the drop rate on its falling edge
    always_comb begin
        rise        = sync1_q & ~prev_q;
        fall        = prev_q & ~sync1_q;
        edge_d      = rise;
        edge_d.drop = fall.drop;
    end

    // Registered pulses, one clock wide
    assign drop_tick_o = pulse_q.drop;
    assign left_o      = pulse_q.left;
    assign right_o     = pulse_q.right;
    assign rot_cw_o    = pulse_q.rot_cw;
    assign rot_ccw_o   = pulse_q.rot_ccw;

endmodule

`default_nettype wire

/* logic/piece_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_controller (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_i,
    input  logic              drop_tick_i,
    input  logic              left_i,
    input  logic              right_i,
    input  logic              rot_cw_i,
    input  logic              rot_ccw_i,
    input  board_pkg::board_t board_i,
    input  logic              clear_done_i,
    output board_pkg::board_t mask_o,
    output logic              merge_o,
    output logic              clear_start_o,
    output logic              show_piece_o,
    output logic              gameover_o
);

    import board_pkg::*;
    import piece_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SPAWN,
        ST_FALLING,
        ST_ROTATE,
        ST_STUCK,
        ST_LANDED,
        ST_EVAL,
        ST_GAMEOVER
    } state_t;

    state_t           state_q, state_d;
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_q;
    piece_t           piece_q, cand_piece;
    shape_t           next_shape_q;
    logic             rot_ccw_q;
    pattern_t         cur_pattern, cand_pattern;
    logic             blocked_bottom, blocked_left, blocked_right, rot_ok;

    // True when every cell of p lands inside the board on a free cell
    function automatic logic fits(pattern_t p, int r0, int c0, board_t b);
        logic ok;
        int   r, c;
        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                r = r0 + i;
                c = c0 + j;
                if (p[i][j]) begin
                    if (r < 0 || r >= BOARD_ROWS || c < 0 || c >= BOARD_COLS)
                        ok = 1'b0;
                    else if (b[r][c])
                        ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    //========================================
    // Shape lookups
    //========================================

    // Current pose, plus its successor in the latched direction
    piece_rom u_rom_cur (
        .piece_i   (piece_q),
        .ccw_i     (rot_ccw_q),
        .pattern_o (cur_pattern),
        .next_o    (cand_piece)
    );

    // Cells of the rotation candidate
    piece_rom u_rom_cand (
        .piece_i   (cand_piece),
        .ccw_i     (rot_ccw_q),
        .pattern_o (cand_pattern),
        .next_o    ()
    );

    //========================================
    // Collision and mask
    //========================================

    always_comb begin
        blocked_bottom = !fits(cur_pattern, int'(row_q) + 1, int'(col_q), board_i);
        blocked_left   = !fits(cur_pattern, int'(row_q), int'(col_q) - 1, board_i);
        blocked_right  = !fits(cur_pattern, int'(row_q), int'(col_q) + 1, board_i);
        rot_ok         = fits(cand_pattern, int'(row_q), int'(col_q), board_i);
    end

    // Falling piece drawn at its board position, clipped at the edges
    always_comb begin
        mask_o = '0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (cur_pattern[i][j] && int'(row_q) + i < BOARD_ROWS &&
                    int'(col_q) + j < BOARD_COLS)
                    mask_o[int'(row_q) + i][int'(col_q) + j] = 1'b1;
            end
        end
    end

    //========================================
    // Game FSM
    //========================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (start_i) state_d = ST_SPAWN;
            ST_SPAWN:   state_d = ST_FALLING;
            ST_FALLING: begin
                // Drop tick wins over moves in the same cycle
                if (drop_tick_i && blocked_bottom)
                    state_d = ST_STUCK;
                else if (!drop_tick_i && !left_i && !right_i && (rot_cw_i || rot_ccw_i))
                    state_d = ST_ROTATE;
            end
            ST_ROTATE:  state_d = ST_FALLING;
            // Piece touching the top row ends the game
            ST_STUCK:   state_d = (|mask_o[0]) ? ST_GAMEOVER : ST_LANDED;
            ST_LANDED:  state_d = ST_EVAL;
            ST_EVAL:    if (clear_done_i) state_d = ST_SPAWN;
            default:    state_d = ST_GAMEOVER;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    // Position, piece code and spawn order
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            row_q        <= '0;
            col_q        <= COL_W'(SPAWN_COL);
            piece_q      <= '{SHAPE_I, 2'd0};
            next_shape_q <= SHAPE_I;
            rot_ccw_q    <= 1'b0;
        end else begin
            case (state_q)
                ST_SPAWN: begin
                    row_q   <= '0;
                    col_q   <= COL_W'(SPAWN_COL);
                    piece_q <= '{next_shape_q, 2'd0};
                    // Fixed cyclic order, T wraps back to I
                    if (next_shape_q == shape_t'(NUM_SHAPES - 1))
                        next_shape_q <= SHAPE_I;
                    else
                        next_shape_q <= shape_t'(next_shape_q + 3'd1);
                end
                ST_FALLING: begin
                    if (drop_tick_i) begin
                        if (!blocked_bottom)
                            row_q <= row_q + ROW_W'(1);
                    end else if (left_i) begin
                        if (!blocked_left)
                            col_q <= col_q - COL_W'(1);
                    end else if (right_i) begin
                        if (!blocked_right)
                            col_q <= col_q + COL_W'(1);
                    end else if (rot_cw_i || rot_ccw_i) begin
                        // Clockwise wins if both buttons fire together
                        rot_ccw_q <= rot_ccw_i & ~rot_cw_i;
                    end
                end
                // Collide means no rotation at all
                ST_ROTATE: if (rot_ok) piece_q <= cand_piece;
                default: ;
            endcase
        end
    end

    // One-cycle strobes straight from the state
    assign merge_o       = (state_q == ST_STUCK);
    assign clear_start_o = (state_q == ST_LANDED);
    assign gameover_o    = (state_q == ST_GAMEOVER);
    assign show_piece_o  = !(state_q inside {ST_IDLE, ST_EVAL, ST_GAMEOVER});

endmodule

`default_nettype wire

/* logic/piece_pkg.sv */
`default_nettype none

// Piece encodings shared by the ROM and the controller
package piece_pkg;

    //========================================
    // Shapes and orientation
    //========================================

    // Seven shapes, spawned in this order
    typedef enum logic [2:0] {
        SHAPE_I,
        SHAPE_O,
        SHAPE_S,
        SHAPE_Z,
        SHAPE_J,
        SHAPE_L,
        SHAPE_T
    } shape_t;

    localparam int NUM_SHAPES = 7;

    // Quarter turns clockwise from the spawn pose
    typedef logic [1:0] orient_t;

    // Piece code as seen by the ROM
    typedef struct packed {
        shape_t  shape;
        orient_t orient;
    } piece_t;

    //========================================
    // Cell pattern
    //========================================

    // 4x4 grid, first index is the row from the top,
    // second is the column from the left
    typedef logic [0:3][0:3] pattern_t;

    // Left column of the pattern box at spawn
    localparam int SPAWN_COL = 3;

endpackage

`default_nettype wire

/* logic/piece_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_rom (
    input  piece_pkg::piece_t   piece_i,
    input  logic                ccw_i,
    output piece_pkg::pattern_t pattern_o,
    output piece_pkg::piece_t   next_o
);

    import piece_pkg::*;

    //========================================
    // Cell patterns, one row per nibble
    //========================================

    // Leftmost bit of each nibble is column 0
    always_comb begin
        case ({piece_i.shape, piece_i.orient})
            // I, vertical then horizontal
            {SHAPE_I, 2'd0}: pattern_o = 16'b1000_1000_1000_1000;
            {SHAPE_I, 2'd1}: pattern_o = 16'b1111_0000_0000_0000;
            // O has a single pose
            {SHAPE_O, 2'd0}: pattern_o = 16'b1100_1100_0000_0000;
            // S and Z, flat then upright
            {SHAPE_S, 2'd0}: pattern_o = 16'b0110_1100_0000_0000;
            {SHAPE_S, 2'd1}: pattern_o = 16'b1000_1100_0100_0000;
            {SHAPE_Z, 2'd0}: pattern_o = 16'b1100_0110_0000_0000;
            {SHAPE_Z, 2'd1}: pattern_o = 16'b0100_1100_1000_0000;
            // J, clockwise sequence
            {SHAPE_J, 2'd0}: pattern_o = 16'b1000_1110_0000_0000;
            {SHAPE_J, 2'd1}: pattern_o = 16'b1100_1000_1000_0000;
            {SHAPE_J, 2'd2}: pattern_o = 16'b1110_0010_0000_0000;
            {SHAPE_J, 2'd3}: pattern_o = 16'b0100_0100_1100_0000;
            // L, clockwise sequence
            {SHAPE_L, 2'd0}: pattern_o = 16'b0010_1110_0000_0000;
            {SHAPE_L, 2'd1}: pattern_o = 16'b1000_1000_1100_0000;
            {SHAPE_L, 2'd2}: pattern_o = 16'b1110_1000_0000_0000;
            {SHAPE_L, 2'd3}: pattern_o = 16'b1100_0100_0100_0000;
            // T, nose up, right, down, left
            {SHAPE_T, 2'd0}: pattern_o = 16'b0100_1110_0000_0000;
            {SHAPE_T, 2'd1}: pattern_o = 16'b1000_1100_1000_0000;
            {SHAPE_T, 2'd2}: pattern_o = 16'b1110_0100_0000_0000;
            {SHAPE_T, 2'd3}: pattern_o = 16'b0100_1100_0100_0000;
            // Unused codes draw nothing
            default:         pattern_o = '0;
        endcase
    end

    //========================================
    // Rotation successor
    //========================================

    always_comb begin
        next_o.shape = piece_i.shape;
        case (piece_i.shape)
            // Square is rotation invariant
            SHAPE_O: next_o.orient = piece_i.orient;
            // Two-pose shapes just toggle, direction irrelevant
            SHAPE_I, SHAPE_S, SHAPE_Z: next_o.orient = {1'b0, ~piece_i.orient[0]};
            // Four-pose shapes step forward or back
            default: begin
                if (ccw_i)
                    next_o.orient = piece_i.orient - 2'd1;
                else
                    next_o.orient = piece_i.orient + 2'd1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/tetris_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_i,
    input  logic              drop_rate_i,
    input  logic              left_i,
    input  logic              right_i,
    input  logic              rot_cw_i,
    input  logic              rot_ccw_i,
    output board_pkg::board_t display_o,
    output board_pkg::score_t score_o,
    output logic              gameover_o
);

    import board_pkg::*;

    // Event pulses
    logic drop_tick, left, right, rot_cw, rot_ccw;

    // Controller to board keeper
    board_t mask, board;
    logic   merge, clear_start, clear_done, show_piece;

    // Input side
    input_conditioner u_input_conditioner (
        .clk         (clk),
        .reset       (reset),
        .drop_rate_i (drop_rate_i),
        .left_i      (left_i),
        .right_i     (right_i),
        .rot_cw_i    (rot_cw_i),
        .rot_ccw_i   (rot_ccw_i),
        .drop_tick_o (drop_tick),
        .left_o      (left),
        .right_o     (right),
        .rot_cw_o    (rot_cw),
        .rot_ccw_o   (rot_ccw)
    );

    // Game FSM and falling piece
    piece_controller u_piece_controller (
        .clk           (clk),
        .reset         (reset),
        .start_i       (start_i),
        .drop_tick_i   (drop_tick),
        .left_i        (left),
        .right_i       (right),
        .rot_cw_i      (rot_cw),
        .rot_ccw_i     (rot_ccw),
        .board_i       (board),
        .clear_done_i  (clear_done),
        .mask_o        (mask),
        .merge_o       (merge),
        .clear_start_o (clear_start),
        .show_piece_o  (show_piece),
        .gameover_o    (gameover_o)
    );

    // Stored board, row clearing, score and display
    board_keeper u_board_keeper (
        .clk           (clk),
        .reset         (reset),
        .mask_i        (mask),
        .merge_i       (merge),
        .clear_start_i (clear_start),
        .show_piece_i  (show_piece),
        .board_o       (board),
        .clear_done_o  (clear_done),
        .display_o     (display_o),
        .score_o       (score_o)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f all.f --top-module tetris_tb -o tetris_sim
./obj_dir/tetris_sim > sim.log 2>&1
cat sim.log
if grep -q "Done: errors found" sim.log; then
    exit 1
fi
grep -q "Done: no errors" sim.log

/* verification/tetris_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_checker (
    input  logic              clk,
    input  logic              check_i,
    input  int                step_i,
    input  board_pkg::board_t display_i,
    input  board_pkg::score_t score_i,
    input  logic              gameover_i,
    input  board_pkg::board_t exp_display_i,
    input  board_pkg::score_t exp_score_i,
    input  logic              exp_gameover_i,
    output int                errors_o
);

    import board_pkg::*;

    int error_count = 0;

    assign errors_o = error_count;

    //========================================
    // Comparison
    //========================================

    task automatic compare_outputs();
        // Score and game over flag first
        if (score_i !== exp_score_i) begin
            $display("Mismatch at %0t: step %0d score is %0d, expected %0d",
                     $time, step_i, score_i, exp_score_i);
            error_count++;
        end
        if (gameover_i !== exp_gameover_i) begin
            $display("Mismatch at %0t: step %0d gameover is %b, expected %b",
                     $time, step_i, gameover_i, exp_gameover_i);
            error_count++;
        end
        // Display row by row, top row first
        for (int r = 0; r < BOARD_ROWS; r++) begin
            if (display_i[r] !== exp_display_i[r]) begin
                $display("Mismatch at %0t: step %0d display row %0d is %h, expected %h",
                         $time, step_i, r, display_i[r], exp_display_i[r]);
                error_count++;
            end
        end
    endtask

    // Values read here are those settled before this edge
    always @(posedge clk) begin
        if (check_i)
            compare_outputs();
    end

endmodule

`default_nettype wire

/* verification/tetris_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_tb;

    import board_pkg::*;

    localparam int MAX_STEPS    = 64;
    localparam int RESET_CYCLES = 16;
    localparam int SLACK_CYCLES = 200;

    // Each rep holds the levels for hold cycles and then releases them
    typedef struct packed {
        logic        start;
        logic        drop;
        logic        left;
        logic        right;
        logic        rot_cw;
        logic        rot_ccw;
        logic [15:0] reps;
        logic [15:0] hold;
        logic        check;
    } step_t;

    // Expected DUT outputs after a checked step
    typedef struct packed {
        score_t  score;
        logic    gameover;
        board_t  display;
    } expect_t;

    logic    clk;
    logic    reset;
    logic    start, drop_rate, left, right, rot_cw, rot_ccw;
    board_t  display;
    score_t  score;
    logic    gameover;

    step_t   steps [MAX_STEPS];
    expect_t expects [MAX_STEPS];
    int      num_steps;
    int      trace_errors;
    int      mismatches;
    int      cycle_count = 0;
    int      cycle_limit;
    logic    check_req;
    expect_t exp_q;
    int      step_idx;

    //========================================
    // Clock, DUT and checker
    //========================================

    always #20 clk = ~clk;

    tetris_top u_tetris_top (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start),
        .drop_rate_i (drop_rate),
        .left_i      (left),
        .right_i     (right),
        .rot_cw_i    (rot_cw),
        .rot_ccw_i   (rot_ccw),
        .display_o   (display),
        .score_o     (score),
        .gameover_o  (gameover)
    );

    tetris_checker u_checker (
        .clk            (clk),
        .check_i        (check_req),
        .step_i         (step_idx),
        .display_i      (display),
        .score_i        (score),
        .gameover_i     (gameover),
        .exp_display_i  (exp_q.display),
        .exp_score_i    (exp_q.score),
        .exp_gameover_i (exp_q.gameover),
        .errors_o       (mismatches)
    );

    //========================================
    // Trace loading
    //========================================

    task automatic load_trace();
        int      fd;
        int      n;
        int      line_no;
        int      v [9];
        int      sc, go, rv;
        string   line;
        step_t   s;
        expect_t e;
        line_no = 0;
        fd = $fopen("verification/tetris_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open trace file verification/tetris_trace.txt");
            trace_errors++;
            return;
        end
        while (!$feof(fd) && trace_errors == 0) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n <= 0)
                continue;
            // Skip comments and blank lines
            if (line.getc(0) == "#" || line.getc(0) == "\n")
                continue;
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
            if (n != 9) begin
                $display("Trace line %0d is malformed, expected nine step fields", line_no);
                trace_errors++;
            end else if (num_steps >= MAX_STEPS) begin
                $display("Trace has more than %0d steps", MAX_STEPS);
                trace_errors++;
            end else begin
                s.start   = v[0][0];
                s.drop    = v[1][0];
                s.left    = v[2][0];
                s.right   = v[3][0];
                s.rot_cw  = v[4][0];
                s.rot_ccw = v[5][0];
                s.reps    = 16'(v[6]);
                s.hold    = 16'(v[7]);
                s.check   = v[8][0];
                e = '0;
                // Expected values sit on the line after a checked step
                if (s.check) begin
                    n = $fscanf(fd, "%h %h", sc, go);
                    if (n != 2)
                        trace_errors++;
                    e.score    = score_t'(sc);
                    e.gameover = go[0];
                    for (int r = 0; r < BOARD_ROWS; r++) begin
                        n = $fscanf(fd, "%h", rv);
                        if (n != 1)
                            trace_errors++;
                        e.display[r] = row_t'(rv);
                    end
                    if (trace_errors != 0)
                        $display("Trace line %0d has incomplete expected values",
                                 line_no + 1);
                end
                steps[num_steps]   = s;
                expects[num_steps] = e;
                num_steps++;
            end
        end
        $fclose(fd);
        if (num_steps == 0 && trace_errors == 0) begin
            $display("Trace file holds no steps");
            trace_errors++;
        end
    endtask

    // Cycles the whole trace needs when every step runs to completion
    function automatic int run_length();
        int total;
        total = 0;
        for (int i = 0; i < num_steps; i++)
            total += int'(steps[i].reps) * 2 * int'(steps[i].hold) + 1;
        return total;
    endfunction

    //========================================
    // Stimulus
    //========================================

    task automatic release_inputs();
        start     = 1'b0;
        drop_rate = 1'b0;
        left      = 1'b0;
        right     = 1'b0;
        rot_cw    = 1'b0;
        rot_ccw   = 1'b0;
    endtask

    // Called on a falling edge and returns on one
    task automatic apply_step(input step_t s);
        repeat (s.reps) begin
            start     = s.start;
            drop_rate = s.drop;
            left      = s.left;
            right     = s.right;
            rot_cw    = s.rot_cw;
            rot_ccw   = s.rot_ccw;
            repeat (s.hold) @(negedge clk);
            // Release gives button presses and the drop tick edge
            release_inputs();
            repeat (s.hold) @(negedge clk);
        end
    endtask

    task automatic report_result();
        $display("Error count: %0d mismatches, %0d trace problems",
                 mismatches, trace_errors);
        if (mismatches == 0 && trace_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    //========================================
    // Timeout
    //========================================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    //========================================
    // Main sequence
    //========================================

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        check_req    = 1'b0;
        exp_q        = '0;
        step_idx     = 0;
        num_steps    = 0;
        trace_errors = 0;
        cycle_limit  = 0;
        release_inputs();
        load_trace();
        cycle_limit = run_length() + RESET_CYCLES + SLACK_CYCLES;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        if (trace_errors == 0) begin
            for (int i = 0; i < num_steps; i++) begin
                step_idx = i;
                apply_step(steps[i]);
                // Checker samples on the next rising edge
                if (steps[i].check) begin
                    exp_q     = expects[i];
                    check_req = 1'b1;
                    @(negedge clk);
                    check_req = 1'b0;
                end
            end
        end
        report_result();
    end

endmodule

`default_nettype wire

/* verification/tetris_trace.txt */
# step: start drop left right cw ccw reps hold check
# after a checked step: score gameover row0 .. row19 (hex, bit n is column n)
0 0 0 0 0 0 1 4 1
00 0 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
1 0 0 0 0 0 1 4 1
00 0 008 008 008 008 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
0 0 1 0 0 0 4 4 1
00 0 001 001 001 001 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
0 0 0 1 0 0 10 4 1
00 0 200 200 200 200 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
0 0 0 0 1 0 1 4 1
00 0 200 200 200 200 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
0 1 0 0 0 0 16 4 0
0 1 0 0 0 0 1 32 1
00 0 018 018 000 000 000 000 000 000 000 000 000 000 000 000 000 000 200 200 200 200
0 0 0 0 1 0 1 4 1
00 0 018 018 000 000 000 000 000 000 000 000 000 000 000 000 000 000 200 200 200 200
0 0 0 1 0 0 4 4 0
0 1 0 0 0 0 18 4 0
0 0 0 1 0 0 1 4 1
00 0 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 200 200 380 380
0 1 0 0 0 0 1 32 1
00 0 030 018 000 000 000 000 000 000 000 000 000 000 000 000 000 000 200 200 380 380
0 0 0 1 0 0 4 4 0
0 1 0 0 0 0 16 32 0
0 0 0 1 0 0 4 4 0
0 1 0 0 0 0 14 32 0
0 0 1 0 0 0 3 4 0
0 1 0 0 0 0 19 32 0
0 0 0 1 0 0 1 4 0
0 1 0 0 0 0 19 32 1
00 0 010 038 000 000 000 000 000 000 000 000 000 000 000 180 300 300 380 200 3c1 3f7
0 0 0 0 1 0 1 4 1
00 0 008 018 008 000 000 000 000 000 000 000 000 000 000 180 300 300 380 200 3c1 3f7
0 0 0 0 1 0 1 4 1
00 0 038 010 000 000 000 000 000 000 000 000 000 000 000 180 300 300 380 200 3c1 3f7
0 0 0 0 0 1 1 4 1
00 0 008 018 008 000 000 000 000 000 000 000 000 000 000 180 300 300 380 200 3c1 3f7
0 1 0 0 0 0 18 32 1
01 0 008 008 008 008 000 000 000 000 000 000 000 000 000 000 180 300 300 380 208 3d9
0 1 0 0 0 0 15 32 0
0 1 0 0 0 0 13 32 0
0 1 0 0 0 0 11 32 0
0 1 0 0 0 0 9 32 0
0 1 0 0 0 0 7 32 0
0 1 0 0 0 0 5 32 0
0 1 0 0 0 0 3 32 0
0 1 0 0 0 0 1 32 1
01 1 008 008 018 038 020 038 008 038 018 030 030 018 018 018 188 308 308 388 208 3d9
1 1 1 0 0 0 2 8 1
01 1 008 008 018 038 020 038 008 038 018 030 030 018 018 018 188 308 308 388 208 3d9
0 1 0 1 1 1 2 8 1
01 1 008 008 018 038 020 038 008 038 018 030 030 018 018 018 188 308 308 388 208 3d9
